// File: sources.f
+incdir+rtl
rtl/pagerank_pkg.sv
rtl/cu_pacing.sv
rtl/cu_cmd_queue.sv
rtl/cu_edge_walker.sv
rtl/cu_rank_fetch.sv
rtl/cu_rank_sum.sv
rtl/cu_read_port.sv
rtl/cu_vertex_pagerank.sv
test/cu_vertex_pagerank_properties.sv
test/tb_cu_vertex_pagerank.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_cu_vertex_pagerank
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_cu_vertex_pagerank.sv
// Testbench for the PageRank vertex compute unit with a random memory model
`timescale 1ns/1ps
`include "pagerank_settings.svh"

module tb_cu_vertex_pagerank;

	import pagerank_pkg::*;

	localparam int NUM_JOBS     = 40;
	localparam int ZERO_JOB     = 5;
	localparam int PAUSE_JOB    = 20;
	localparam int JOB_TIMEOUT  = 2000;
	localparam int DONE_TIMEOUT = 2000;

	logic                 clock;
	logic                 rstn;
	logic                 enable;
	logic                 job_valid;
	logic                 job_ready;
	vertex_job_t          job;
	logic                 read_cmd_valid;
	logic                 read_cmd_ready;
	read_cmd_t            read_cmd;
	logic                 read_rsp_valid;
	logic                 read_rsp_ready;
	read_rsp_t            read_rsp;
	logic                 write_cmd_valid;
	logic                 write_cmd_ready;
	write_cmd_t           write_cmd;
	logic                 write_rsp_valid;
	logic [`VERTEX_W-1:0] vertex_count;
	logic [`EDGE_W-1:0]   edge_count;

	// Memory model state
	logic [15:0] edge_mem [256];
	logic [31:0] rank_mem [512];
	read_rsp_t   rsp_queue [$];
	int          rsp_due [$];
	write_cmd_t  exp_writes [$];
	int          cycle = 0;
	int          last_read_cycle = -1;
	int          wr_wait = 0;
	logic        read_quiet;
	int          value_errors = 0;
	int          other_errors = 0;

	cu_vertex_pagerank u_cu_vertex_pagerank (
		.clock          (clock),
		.rstn           (rstn),
		.enable         (enable),
		.job_valid      (job_valid),
		.job_ready      (job_ready),
		.job            (job),
		.read_cmd_valid (read_cmd_valid),
		.read_cmd_ready (read_cmd_ready),
		.read_cmd       (read_cmd),
		.read_rsp_valid (read_rsp_valid),
		.read_rsp_ready (read_rsp_ready),
		.read_rsp       (read_rsp),
		.write_cmd_valid(write_cmd_valid),
		.write_cmd_ready(write_cmd_ready),
		.write_cmd      (write_cmd),
		.write_rsp_valid(write_rsp_valid),
		.vertex_count   (vertex_count),
		.edge_count     (edge_count)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			value_errors++;
			$display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
		end
	endtask

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////

	task automatic accept_read(input read_cmd_t cmd, input logic quiet);
		read_rsp_t rsp;
		if (quiet) begin
			other_errors++;
			$display("A read command was accepted while enable was low");
		end
		if (last_read_cycle >= 0 && cycle - last_read_cycle < `ISSUE_INTERVAL) begin
			other_errors++;
			$display("Two read commands were accepted only %0d cycles apart",
				cycle - last_read_cycle);
		end
		last_read_cycle = cycle;
		rsp.tag  = cmd.tag;
		rsp.data = '0;
		case (cmd.tag)
			EDGE_ARRAY_DEST: begin
				if (cmd.addr < 16'd256) begin
					rsp.data = 32'(edge_mem[cmd.addr[7:0]]);
				end else begin
					other_errors++;
					$display("An edge-array read fell outside the edge array");
				end
			end
			READ_GRAPH_DATA: begin
				if (cmd.addr < 16'd512) begin
					rsp.data = rank_mem[cmd.addr[8:0]];
				end else begin
					other_errors++;
					$display("A rank read fell outside the graph data array");
				end
			end
			default: begin
				other_errors++;
				$display("A read command carried a write tag");
			end
		endcase
		rsp_queue.push_back(rsp);
		rsp_due.push_back(cycle + int'($urandom % 6));
	endtask

	task automatic accept_write(input write_cmd_t cmd);
		write_cmd_t exp;
		if (exp_writes.size() == 0) begin
			other_errors++;
			$display("A vertex write arrived with no job outstanding");
		end else begin
			exp = exp_writes.pop_front();
			check_value("write_cmd.addr", 32'(cmd.addr), 32'(exp.addr));
			check_value("write_cmd.data", cmd.data, exp.data);
		end
		if (cmd.addr < 16'd512) begin
			rank_mem[cmd.addr[8:0]] = cmd.data;
		end
		wr_wait = 1 + int'($urandom % 4);
	endtask

	// Responses go out in order and each is held until taken
	task automatic drive_read_rsp(input logic taken);
		if (taken) begin
			void'(rsp_queue.pop_front());
			void'(rsp_due.pop_front());
			read_rsp_valid = 1'b0;
		end
		if (!read_rsp_valid && rsp_queue.size() > 0 && rsp_due[0] <= cycle
				&& ($urandom % 4) != 0) begin
			read_rsp       = rsp_queue[0];
			read_rsp_valid = 1'b1;
		end
	endtask

	initial begin
		logic       live;
		logic       quiet;
		logic       rd_fire;
		logic       rsp_fire;
		logic       wr_fire;
		read_cmd_t  rd_cmd;
		write_cmd_t wr_cmd;
		read_cmd_ready  = 1'b0;
		read_rsp_valid  = 1'b0;
		read_rsp        = '0;
		write_cmd_ready = 1'b0;
		write_rsp_valid = 1'b0;
		forever begin
			// Handshakes sampled mid-cycle where they are settled
			@(negedge clock);
			live     = rstn;
			quiet    = read_quiet;
			rd_fire  = read_cmd_valid && read_cmd_ready;
			rsp_fire = read_rsp_valid && read_rsp_ready;
			wr_fire  = write_cmd_valid && write_cmd_ready;
			rd_cmd   = read_cmd;
			wr_cmd   = write_cmd;
			@(posedge clock);
			#2;
			cycle++;
			if (live) begin
				write_rsp_valid = 1'b0;
				if (wr_wait > 0) begin
					wr_wait--;
					write_rsp_valid = (wr_wait == 0);
				end
				if (rd_fire) begin
					accept_read(rd_cmd, quiet);
				end
				if (wr_fire) begin
					accept_write(wr_cmd);
				end
				drive_read_rsp(rsp_fire);
				read_cmd_ready  = ($urandom % 4) != 0;
				write_cmd_ready = ($urandom % 2) != 0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Jobs and reference sums
	//////////////////////////////////////////////////

	function automatic logic [31:0] reference_sum(input vertex_job_t jb);
		logic [31:0] sum;
		logic [15:0] idx;
		sum = '0;
		for (int i = 0; i < int'(jb.out_degree); i++) begin
			idx = jb.edge_start + 16'(i);
			sum = sum + rank_mem[9'(edge_mem[idx[7:0]])];
		end
		return sum;
	endfunction

	// Job vertices live above the rank region so writes never feed later sums
	function automatic vertex_job_t random_job(input int k);
		vertex_job_t jb;
		jb.vertex_id  = 16'(256 + ($urandom % 256));
		jb.edge_start = 16'($urandom % 248);
		jb.out_degree = 16'($urandom % 9);
		if (k == ZERO_JOB) begin
			jb.out_degree = '0;
		end
		if (k == PAUSE_JOB) begin
			jb.out_degree = 16'd8;
		end
		return jb;
	endfunction

	task automatic submit_job(input vertex_job_t jb, output logic timed_out);
		int   waited;
		logic taken;
		waited    = 0;
		taken     = 1'b0;
		timed_out = 1'b0;
		job       = jb;
		job_valid = 1'b1;
		while (!taken && !timed_out) begin
			@(negedge clock);
			taken = job_ready;
			waited++;
			if (!taken && waited >= JOB_TIMEOUT) begin
				other_errors++;
				timed_out = 1'b1;
				$display("Timed out waiting for the unit to take vertex 0x%04h", jb.vertex_id);
			end
			@(posedge clock);
			#2;
		end
		job_valid = 1'b0;
	endtask

	// enable held low for 30 cycles with reads checked from its first effective edge
	task automatic pause_reads();
		repeat (3) @(posedge clock);
		#2;
		enable = 1'b0;
		@(posedge clock);
		#2;
		read_quiet = 1'b1;
		repeat (29) @(posedge clock);
		#2;
		enable     = 1'b1;
		read_quiet = 1'b0;
	endtask

	task automatic wait_all_done(output logic timed_out);
		int   waited;
		logic done;
		waited    = 0;
		done      = 1'b0;
		timed_out = 1'b0;
		while (!done && !timed_out) begin
			@(negedge clock);
			waited++;
			if (vertex_count == `VERTEX_W'(NUM_JOBS)) begin
				done = 1'b1;
			end else if (waited >= DONE_TIMEOUT) begin
				other_errors++;
				timed_out = 1'b1;
				$display("Timed out waiting for all vertices to complete");
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		vertex_job_t jb;
		write_cmd_t  exp;
		int          total_deg;
		logic        timed_out;
		void'($urandom(52));
		rstn       = 1'b0;
		enable     = 1'b0;
		job_valid  = 1'b0;
		job        = '0;
		read_quiet = 1'b0;
		total_deg  = 0;
		timed_out  = 1'b0;
		for (int i = 0; i < 256; i++) begin
			edge_mem[i] = 16'($urandom % 256);
		end
		for (int i = 0; i < 512; i++) begin
			rank_mem[i] = $urandom;
		end
		repeat (10) @(posedge clock);
		#2;
		rstn = 1'b1;
		@(negedge clock);
		check_value("read_cmd_valid", 32'(read_cmd_valid), 32'h0);
		check_value("write_cmd_valid", 32'(write_cmd_valid), 32'h0);
		check_value("job_ready", 32'(job_ready), 32'h1);
		check_value("vertex_count", 32'(vertex_count), 32'h0);
		check_value("edge_count", 32'(edge_count), 32'h0);
		@(posedge clock);
		#2;
		enable = 1'b1;
		for (int k = 0; k < NUM_JOBS && !timed_out; k++) begin
			jb       = random_job(k);
			exp.addr = `ADDR_W'(jb.vertex_id);
			exp.data = reference_sum(jb);
			exp_writes.push_back(exp);
			total_deg += int'(jb.out_degree);
			submit_job(jb, timed_out);
			if (k == PAUSE_JOB && !timed_out) begin
				pause_reads();
			end
		end
		if (!timed_out) begin
			wait_all_done(timed_out);
		end
		check_value("vertex_count", 32'(vertex_count), 32'(NUM_JOBS));
		check_value("edge_count", 32'(edge_count), 32'(total_deg % 65536));
		if (exp_writes.size() != 0) begin
			other_errors++;
			$display("%0d vertex writes never arrived", exp_writes.size());
		end
		if (rsp_queue.size() != 0) begin
			other_errors++;
			$display("%0d read responses were never taken", rsp_queue.size());
		end
		$display("Errors: %0d value mismatches, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: test/cu_vertex_pagerank_properties.sv
// Handshake and read pacing assertions bound into the PageRank compute unit
`timescale 1ns/1ps
`include "pagerank_settings.svh"

module cu_vertex_pagerank_properties (
	input logic                     clock,
	input logic                     rstn,
	input logic                     read_cmd_valid,
	input logic                     read_cmd_ready,
	input pagerank_pkg::read_cmd_t  read_cmd,
	input logic                     write_cmd_valid,
	input logic                     write_cmd_ready,
	input pagerank_pkg::write_cmd_t write_cmd
);

	import pagerank_pkg::*;

	logic       read_stalled;
	read_cmd_t  stalled_cmd;
	logic       read_seen;
	logic [7:0] since_read;

	// Last refused read command and cycles since the last accepted one
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_stalled <= 1'b0;
			stalled_cmd  <= '0;
			read_seen    <= 1'b0;
			since_read   <= '0;
		end else if (read_cmd_valid && read_cmd_ready) begin
			read_stalled <= 1'b0;
			read_seen    <= 1'b1;
			since_read   <= 8'd1;
		end else begin
			if (read_cmd_valid) begin
				read_stalled <= 1'b1;
				stalled_cmd  <= read_cmd;
			end
			if (since_read != 8'hff) begin
				since_read <= since_read + 8'd1;
			end
		end
	end

	// Read valid shows only in slots, so a refused command returns unchanged
	read_retry_same: assert property (@(posedge clock) disable iff (!rstn)
		(read_stalled && read_cmd_valid) |-> (read_cmd == stalled_cmd))
		else $error("refused read command came back changed");

	write_hold: assert property (@(posedge clock) disable iff (!rstn)
		(write_cmd_valid && !write_cmd_ready) |=> (write_cmd_valid && $stable(write_cmd)))
		else $error("write command dropped or changed before its transfer");

	read_spacing: assert property (@(posedge clock) disable iff (!rstn)
		(read_cmd_valid && read_cmd_ready && read_seen)
			|-> (since_read >= 8'(`ISSUE_INTERVAL)))
		else $error("read commands accepted closer than the issue interval");

endmodule

bind cu_vertex_pagerank cu_vertex_pagerank_properties u_cu_vertex_pagerank_properties (
	.clock          (clock),
	.rstn           (rstn),
	.read_cmd_valid (read_cmd_valid),
	.read_cmd_ready (read_cmd_ready),
	.read_cmd       (read_cmd),
	.write_cmd_valid(write_cmd_valid),
	.write_cmd_ready(write_cmd_ready),
	.write_cmd      (write_cmd)
);

// File: rtl/cu_vertex_pagerank.sv
// PageRank vertex compute unit top level joining walker, fetch, sum and read port
`timescale 1ns/1ps
`include "pagerank_settings.svh"

module cu_vertex_pagerank (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enable,
	input  logic                      job_valid,
	output logic                      job_ready,
	input  pagerank_pkg::vertex_job_t  job,
	output logic                      read_cmd_valid,
	input  logic                      read_cmd_ready,
	output pagerank_pkg::read_cmd_t    read_cmd,
	input  logic                      read_rsp_valid,
	output logic                      read_rsp_ready,
	input  pagerank_pkg::read_rsp_t    read_rsp,
	output logic                      write_cmd_valid,
	input  logic                      write_cmd_ready,
	output pagerank_pkg::write_cmd_t   write_cmd,
	input  logic                      write_rsp_valid,
	output logic [`VERTEX_W-1:0]      vertex_count,
	output logic [`EDGE_W-1:0]        edge_count
);

	import pagerank_pkg::*;

	logic        slot;
	logic        walk_cmd_valid;
	logic        walk_cmd_ready;
	read_cmd_t   walk_cmd;
	logic        q0_valid;
	logic        q0_ready;
	read_cmd_t   q0_cmd;
	logic        q1_valid;
	logic        q1_ready;
	read_cmd_t   q1_cmd;
	logic        edge_rsp_valid;
	logic        edge_rsp_ready;
	logic        rank_rsp_valid;
	read_rsp_t   rsp_routed;
	vertex_job_t active_job;
	logic        job_active;
	logic        vertex_done;

	//////////////////////////////////////////////////
	// Edge-array read source
	//////////////////////////////////////////////////

	cu_edge_walker u_edge_walker (
		.clock      (clock),
		.rstn       (rstn),
		.job_valid  (job_valid),
		.job_ready  (job_ready),
		.job        (job),
		.vertex_done(vertex_done),
		.cmd_valid  (walk_cmd_valid),
		.cmd_ready  (walk_cmd_ready),
		.cmd        (walk_cmd),
		.active_job (active_job),
		.job_active (job_active)
	);

	cu_cmd_queue u_edge_cmd_queue (
		.clock    (clock),
		.rstn     (rstn),
		.in_valid (walk_cmd_valid),
		.in_ready (walk_cmd_ready),
		.in_cmd   (walk_cmd),
		.out_valid(q0_valid),
		.out_ready(q0_ready),
		.out_cmd  (q0_cmd)
	);

	// Rank read source with its own queue
	cu_rank_fetch u_rank_fetch (
		.clock    (clock),
		.rstn     (rstn),
		.rsp_valid(edge_rsp_valid),
		.rsp_ready(edge_rsp_ready),
		.rsp      (rsp_routed),
		.cmd_valid(q1_valid),
		.cmd_ready(q1_ready),
		.cmd      (q1_cmd)
	);

	//////////////////////////////////////////////////
	// Shared read port and its pacing
	//////////////////////////////////////////////////

	cu_pacing u_pacing (
		.clock (clock),
		.rstn  (rstn),
		.enable(enable),
		.slot  (slot)
	);

	cu_read_port u_read_port (
		.clock         (clock),
		.rstn          (rstn),
		.slot          (slot),
		.q0_valid      (q0_valid),
		.q0_ready      (q0_ready),
		.q0_cmd        (q0_cmd),
		.q1_valid      (q1_valid),
		.q1_ready      (q1_ready),
		.q1_cmd        (q1_cmd),
		.read_cmd_valid(read_cmd_valid),
		.read_cmd_ready(read_cmd_ready),
		.read_cmd      (read_cmd),
		.read_rsp_valid(read_rsp_valid),
		.read_rsp_ready(read_rsp_ready),
		.read_rsp      (read_rsp),
		.edge_rsp_valid(edge_rsp_valid),
		.edge_rsp_ready(edge_rsp_ready),
		.rank_rsp_valid(rank_rsp_valid),
		.rsp_out       (rsp_routed)
	);

	//////////////////////////////////////////////////
	// Accumulate and write back
	//////////////////////////////////////////////////

	cu_rank_sum u_rank_sum (
		.clock          (clock),
		.rstn           (rstn),
		.active_job     (active_job),
		.job_active     (job_active),
		.rsp_valid      (rank_rsp_valid),
		.rsp            (rsp_routed),
		.write_cmd_valid(write_cmd_valid),
		.write_cmd_ready(write_cmd_ready),
		.write_cmd      (write_cmd),
		.write_rsp_valid(write_rsp_valid),
		.vertex_done    (vertex_done),
		.vertex_count   (vertex_count),
		.edge_count     (edge_count)
	);

endmodule

// File: rtl/cu_read_port.sv
// Round-robin read command arbiter and tag-based read response router
`timescale 1ns/1ps

module cu_read_port (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   slot,
	input  logic                   q0_valid,
	output logic                   q0_ready,
	input  pagerank_pkg::read_cmd_t q0_cmd,
	input  logic                   q1_valid,
	output logic                   q1_ready,
	input  pagerank_pkg::read_cmd_t q1_cmd,
	output logic                   read_cmd_valid,
	input  logic                   read_cmd_ready,
	output pagerank_pkg::read_cmd_t read_cmd,
	input  logic                   read_rsp_valid,
	output logic                   read_rsp_ready,
	input  pagerank_pkg::read_rsp_t read_rsp,
	output logic                   edge_rsp_valid,
	input  logic                   edge_rsp_ready,
	output logic                   rank_rsp_valid,
	output pagerank_pkg::read_rsp_t rsp_out
);

	import pagerank_pkg::*;

	logic last_grant;
	logic hold;
	logic hold_sel;
	logic sel;

	//////////////////////////////////////////////////
	// Command arbitration
	//////////////////////////////////////////////////

	// A stalled grant is kept until it transfers
	always_comb begin
		if (hold) begin
			sel = hold_sel;
		end else if (q0_valid && q1_valid) begin
			sel = ~last_grant;
		end else begin
			sel = q1_valid;
		end
	end

	assign read_cmd_valid = slot && (sel ? q1_valid : q0_valid);
	assign read_cmd       = sel ? q1_cmd : q0_cmd;
	assign q0_ready       = slot && !sel && read_cmd_ready;
	assign q1_ready       = slot && sel && read_cmd_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_grant <= 1'b1;
			hold       <= 1'b0;
			hold_sel   <= 1'b0;
		end else if (read_cmd_valid && read_cmd_ready) begin
			last_grant <= sel;
			hold       <= 1'b0;
		end else if (read_cmd_valid) begin
			hold     <= 1'b1;
			hold_sel <= sel;
		end
	end

	//////////////////////////////////////////////////
	// Response routing
	//////////////////////////////////////////////////

	assign rsp_out        = read_rsp;
	assign edge_rsp_valid = read_rsp_valid && (read_rsp.tag == EDGE_ARRAY_DEST);
	assign rank_rsp_valid = read_rsp_valid && (read_rsp.tag == READ_GRAPH_DATA);

	// Rank sink never stalls; unknown tags are dropped
	always_comb begin
		case (read_rsp.tag)
			EDGE_ARRAY_DEST: read_rsp_ready = edge_rsp_ready;
			default:         read_rsp_ready = 1'b1;
		endcase
	end

endmodule

// File: rtl/cu_rank_sum.sv
// Rank accumulator with vertex write-back, completion pulse and counters
`timescale 1ns/1ps
`include "pagerank_settings.svh"

module cu_rank_sum (
	input  logic                      clock,
	input  logic                      rstn,
	input  pagerank_pkg::vertex_job_t  active_job,
	input  logic                      job_active,
	input  logic                      rsp_valid,
	input  pagerank_pkg::read_rsp_t    rsp,
	output logic                      write_cmd_valid,
	input  logic                      write_cmd_ready,
	output pagerank_pkg::write_cmd_t   write_cmd,
	input  logic                      write_rsp_valid,
	output logic                      vertex_done,
	output logic [`VERTEX_W-1:0]      vertex_count,
	output logic [`EDGE_W-1:0]        edge_count
);

	import pagerank_pkg::*;

	sum_state_e         state;
	logic [`RANK_W-1:0] sum;
	logic [`EDGE_W-1:0] edges_seen;
	logic               rank_take;

	assign rank_take       = (state == ACCUM) && rsp_valid;
	assign write_cmd_valid = (state == WRITE);
	assign vertex_done     = (state == WAIT_RSP) && write_rsp_valid;

	always_comb begin
		write_cmd.addr = `ADDR_W'(active_job.vertex_id);
		write_cmd.data = sum;
	end

	//////////////////////////////////////////////////
	// Sum FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= ACCUM;
			sum        <= '0;
			edges_seen <= '0;
		end else begin
			case (state)
				ACCUM: begin
					// Sum wraps modulo 2^32
					if (rank_take) begin
						sum        <= sum + rsp.data;
						edges_seen <= edges_seen + 1'b1;
					end
					if (job_active && (edges_seen == active_job.out_degree)) begin
						state <= WRITE;
					end
				end
				WRITE: begin
					if (write_cmd_ready) begin
						state <= WAIT_RSP;
					end
				end
				WAIT_RSP: begin
					if (write_rsp_valid) begin
						state      <= ACCUM;
						sum        <= '0;
						edges_seen <= '0;
					end
				end
				default: begin
					state <= ACCUM;
				end
			endcase
		end
	end

	// Running totals across all jobs
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			if (vertex_done) begin
				vertex_count <= vertex_count + 1'b1;
			end
			if (rank_take) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

endmodule

// File: rtl/cu_rank_fetch.sv
// Turns neighbor ids from the edge array into graph-data rank reads
`timescale 1ns/1ps
`include "pagerank_settings.svh"

module cu_rank_fetch (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   rsp_valid,
	output logic                   rsp_ready,
	input  pagerank_pkg::read_rsp_t rsp,
	output logic                   cmd_valid,
	input  logic                   cmd_ready,
	output pagerank_pkg::read_cmd_t cmd
);

	import pagerank_pkg::*;

	read_cmd_t rank_cmd;

	// Neighbor id sits in the low bits of the response data
	always_comb begin
		rank_cmd.tag  = READ_GRAPH_DATA;
		rank_cmd.addr = `ADDR_W'(rsp.data[`VERTEX_W-1:0]);
	end

	//////////////////////////////////////////////////
	// Rank read queue
	//////////////////////////////////////////////////

	// Full queue stalls the response router
	cu_cmd_queue u_rank_cmd_queue (
		.clock    (clock),
		.rstn     (rstn),
		.in_valid (rsp_valid),
		.in_ready (rsp_ready),
		.in_cmd   (rank_cmd),
		.out_valid(cmd_valid),
		.out_ready(cmd_ready),
		.out_cmd  (cmd)
	);

endmodule

// File: rtl/cu_edge_walker.sv
// Vertex job holder that issues one edge-array read per outgoing edge
`timescale 1ns/1ps
`include "pagerank_settings.svh"

module cu_edge_walker (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     job_valid,
	output logic                     job_ready,
	input  pagerank_pkg::vertex_job_t job,
	input  logic                     vertex_done,
	output logic                     cmd_valid,
	input  logic                     cmd_ready,
	output pagerank_pkg::read_cmd_t   cmd,
	output pagerank_pkg::vertex_job_t active_job,
	output logic                     job_active
);

	import pagerank_pkg::*;

	walk_state_e        state;
	logic [`EDGE_W-1:0] issued;

	assign job_ready  = (state == IDLE);
	assign job_active = (state == WALK);

	// Edge reads run until every edge has been queued
	assign cmd_valid = (state == WALK) && (issued != active_job.out_degree);

	always_comb begin
		cmd.tag  = EDGE_ARRAY_DEST;
		cmd.addr = `ADDR_W'(active_job.edge_start + issued);
	end

	//////////////////////////////////////////////////
	// Walk FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state  <= IDLE;
			issued <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (job_valid) begin
						state  <= WALK;
						issued <= '0;
					end
				end
				WALK: begin
					if (cmd_valid && cmd_ready) begin
						issued <= issued + 1'b1;
					end
					// Sum kernel signals the write response
					if (vertex_done) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Job payload held for the walk and the sum kernel
	always_ff @(posedge clock) begin
		if (job_valid && job_ready) begin
			active_job <= job;
		end
	end

endmodule

// File: rtl/cu_cmd_queue.sv
// Circular FIFO of read command structs with valid/ready on both sides
`timescale 1ns/1ps
`include "pagerank_settings.svh"

module cu_cmd_queue (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  pagerank_pkg::read_cmd_t in_cmd,
	output logic                   out_valid,
	input  logic                   out_ready,
	output pagerank_pkg::read_cmd_t out_cmd
);

	import pagerank_pkg::*;

	localparam int DEPTH = `CMD_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	read_cmd_t        mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign in_ready  = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_cmd   = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= in_cmd;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves occupancy unchanged
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: rtl/cu_pacing.sv
// Read issue pacing with a registered enable and a free-running slot counter
`timescale 1ns/1ps
`include "pagerank_settings.svh"

module cu_pacing (
	input  logic clock,
	input  logic rstn,
	input  logic enable,
	output logic slot
);

	localparam int CNT_W = (`ISSUE_INTERVAL > 1) ? $clog2(`ISSUE_INTERVAL) : 1;

	logic             enable_q;
	logic [CNT_W-1:0] count;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable_q <= 1'b0;
		end else begin
			enable_q <= enable;
		end
	end

	// Runs whether enabled or not, so slots stay on a fixed grid
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count <= '0;
		end else if (count == CNT_W'(`ISSUE_INTERVAL - 1)) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	assign slot = enable_q && (count == '0);

endmodule

// File: rtl/pagerank_pkg.sv
// Shared types of the PageRank vertex compute unit
`include "pagerank_settings.svh"

package pagerank_pkg;

	//////////////////////////////////////////////////
	// Memory access targets
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		EDGE_ARRAY_DEST  = 2'd0,
		READ_GRAPH_DATA  = 2'd1,
		WRITE_GRAPH_DATA = 2'd2
	} mem_struct_e;

	//////////////////////////////////////////////////
	// Channel payloads
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [`VERTEX_W-1:0] vertex_id;
		logic [`EDGE_W-1:0]   edge_start;
		logic [`EDGE_W-1:0]   out_degree;
	} vertex_job_t;

	typedef struct packed {
		mem_struct_e        tag;
		logic [`ADDR_W-1:0] addr;
	} read_cmd_t;

	// Edge-array data carries the neighbor id in the low bits
	typedef struct packed {
		mem_struct_e        tag;
		logic [`RANK_W-1:0] data;
	} read_rsp_t;

	// Always a graph-data write
	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		logic [`RANK_W-1:0] data;
	} write_cmd_t;

	//////////////////////////////////////////////////
	// FSM states
	//////////////////////////////////////////////////

	typedef enum logic {
		IDLE,
		WALK
	} walk_state_e;

	typedef enum logic [1:0] {
		ACCUM,
		WRITE,
		WAIT_RSP
	} sum_state_e;

endpackage

// File: rtl/pagerank_settings.svh
// PageRank compute unit widths, queue depth and read issue pacing
`ifndef PAGERANK_SETTINGS_SVH
`define PAGERANK_SETTINGS_SVH

//////////////////////////////////////////////////
// Data widths
//////////////////////////////////////////////////

// Vertex id
`define VERTEX_W 16

// Edge index and edge count
`define EDGE_W 16

// Rank value and running sum
`define RANK_W 32

// Memory element index
`define ADDR_W 16

//////////////////////////////////////////////////
// Read path
//////////////////////////////////////////////////

`define CMD_QUEUE_DEPTH 4

// Power of two
`define ISSUE_INTERVAL 4

`endif
